/* rtl/pmp_pkg.sv */
// PMP package
// Shared types, config byte layout and APB register map of the PMP unit

package pmp_pkg;

  // Physical address range covered by the address registers
  localparam int unsigned PMP_ADDR_LSB = 2;
  localparam int unsigned PMP_ADDR_MSB = 33;

  // APB address width
  localparam int unsigned APB_AW = 12;

  // Region config byte, address register and request address
  typedef logic [7:0]            pmp_cfg_t;
  typedef logic [31:0]           pmp_addr_t;
  typedef logic [PMP_ADDR_MSB:0] phys_addr_t;

  // MML, MMWP and RLB
  typedef logic [2:0] mseccfg_t;

  // Bit positions inside pmp_cfg_t
  localparam int unsigned PMP_CFG_R        = 0;
  localparam int unsigned PMP_CFG_W        = 1;
  localparam int unsigned PMP_CFG_X        = 2;
  localparam int unsigned PMP_CFG_MODE_LSB = 3;
  localparam int unsigned PMP_CFG_L        = 7;

  // Bit positions inside mseccfg_t
  localparam int unsigned MSECCFG_MML  = 0;
  localparam int unsigned MSECCFG_MMWP = 1;
  localparam int unsigned MSECCFG_RLB  = 2;

  // Region addressing mode
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // Access type of a request
  typedef enum logic [1:0] {
    PMP_ACC_EXEC  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_READ  = 2'b10
  } pmp_req_e;

  // RISC-V privilege encodings
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // APB register map, one 32-bit word per region
  localparam logic [APB_AW-1:0] REG_CFG_BASE  = 12'h000;
  localparam logic [APB_AW-1:0] REG_ADDR_BASE = 12'h040;
  localparam logic [APB_AW-1:0] REG_MSECCFG   = 12'h080;

endpackage

/* rtl/pmp_apb_regs.sv */
// PMP register block
// APB slave for the region config, region address and mseccfg registers

module pmp_apb_regs #(
  parameter int unsigned PmpNumRegions = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // APB slave
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [pmp_pkg::APB_AW-1:0] paddr_i,
  input  logic [31:0]                pwdata_i,
  output logic [31:0]                prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  // Register contents to the checker
  output pmp_pkg::pmp_cfg_t          cfg_o [PmpNumRegions],
  output pmp_pkg::pmp_addr_t         addr_o [PmpNumRegions],
  output pmp_pkg::mseccfg_t          mseccfg_o
);

  import pmp_pkg::*;

  // Each register window spans 16 words
  localparam int unsigned WinLsb = 6;

  pmp_cfg_t  cfg_q [PmpNumRegions];
  pmp_addr_t addr_q [PmpNumRegions];
  mseccfg_t  mseccfg_q;

  logic [3:0] reg_idx;
  logic       aligned, idx_ok;
  logic       in_cfg, in_addr, in_msec, addr_hit;
  logic       apb_access, wr_en;
  logic       rlb, any_lock;

  logic [PmpNumRegions-1:0] lock_bits;
  logic [PmpNumRegions-1:0] cfg_lock;
  logic [PmpNumRegions-1:0] addr_lock;

  // ------------------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------------------

  assign reg_idx = paddr_i[WinLsb-1:2];
  assign aligned = paddr_i[1:0] == 2'b00;
  // Regions above the implemented count are holes in the map
  assign idx_ok  = reg_idx < PmpNumRegions;

  assign in_cfg   = aligned & idx_ok &
                    (paddr_i[APB_AW-1:WinLsb] == REG_CFG_BASE[APB_AW-1:WinLsb]);
  assign in_addr  = aligned & idx_ok &
                    (paddr_i[APB_AW-1:WinLsb] == REG_ADDR_BASE[APB_AW-1:WinLsb]);
  assign in_msec  = paddr_i == REG_MSECCFG;
  assign addr_hit = in_cfg | in_addr | in_msec;

  // Zero wait states, error only in the access phase
  assign apb_access = psel_i & penable_i;
  assign wr_en      = apb_access & pwrite_i & addr_hit;
  assign pready_o   = 1'b1;
  assign pslverr_o  = apb_access & ~addr_hit;

  // ------------------------------------------------------------------------
  // Lock rules
  // ------------------------------------------------------------------------

  assign rlb      = mseccfg_q[MSECCFG_RLB];
  assign any_lock = |lock_bits;

  for (genvar r = 0; r < PmpNumRegions; r++) begin : g_lock
    assign lock_bits[r] = cfg_q[r][PMP_CFG_L];
    // RLB bypasses every lock
    assign cfg_lock[r]  = lock_bits[r] & ~rlb;
    if (r < PmpNumRegions - 1) begin : g_next
      // A locked TOR region also guards the address below it
      assign addr_lock[r] = cfg_lock[r] |
          (cfg_lock[r+1] & (cfg_q[r+1][PMP_CFG_MODE_LSB +: 2] == PMP_MODE_TOR));
    end else begin : g_last
      assign addr_lock[r] = cfg_lock[r];
    end
  end

  // ------------------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int unsigned r = 0; r < PmpNumRegions; r++) begin
        cfg_q[r]  <= '0;
        addr_q[r] <= '0;
      end
      mseccfg_q <= '0;
    end else if (wr_en) begin
      for (int unsigned r = 0; r < PmpNumRegions; r++) begin
        // Locked registers take the write silently
        if (in_cfg && reg_idx == r && !cfg_lock[r]) begin
          cfg_q[r] <= pwdata_i[7:0];
        end
        if (in_addr && reg_idx == r && !addr_lock[r]) begin
          addr_q[r] <= pwdata_i;
        end
      end
      if (in_msec) begin
        // MML and MMWP are sticky
        mseccfg_q[MSECCFG_MML]  <= mseccfg_q[MSECCFG_MML] | pwdata_i[MSECCFG_MML];
        mseccfg_q[MSECCFG_MMWP] <= mseccfg_q[MSECCFG_MMWP] | pwdata_i[MSECCFG_MMWP];
        if (!any_lock) begin
          mseccfg_q[MSECCFG_RLB] <= pwdata_i[MSECCFG_RLB];
        end
      end
    end
  end

  // Read data mux
  always_comb begin
    prdata_o = '0;
    for (int unsigned r = 0; r < PmpNumRegions; r++) begin
      if (in_cfg && reg_idx == r) begin
        prdata_o = {24'b0, cfg_q[r]};
      end
      if (in_addr && reg_idx == r) begin
        prdata_o = addr_q[r];
      end
    end
    if (in_msec) begin
      prdata_o = {29'b0, mseccfg_q};
    end
  end

  assign cfg_o     = cfg_q;
  assign addr_o    = addr_q;
  assign mseccfg_o = mseccfg_q;

endmodule

/* rtl/pmp_req_fifo.sv */
// PMP request buffer
// Circular FIFO for address, access type and privilege, valid/ready both sides

module pmp_req_fifo #(
  parameter int unsigned ReqFifoDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Write side
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  pmp_pkg::phys_addr_t in_addr_i,
  input  pmp_pkg::pmp_req_e   in_type_i,
  input  pmp_pkg::priv_lvl_e  in_priv_i,
  // Read side
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output pmp_pkg::phys_addr_t out_addr_o,
  output pmp_pkg::pmp_req_e   out_type_o,
  output pmp_pkg::priv_lvl_e  out_priv_o
);

  import pmp_pkg::*;

  localparam int unsigned PtrW = (ReqFifoDepth > 1) ? $clog2(ReqFifoDepth) : 1;
  localparam int unsigned CntW = $clog2(ReqFifoDepth + 1);

  phys_addr_t addr_mem [ReqFifoDepth];
  pmp_req_e   type_mem [ReqFifoDepth];
  priv_lvl_e  priv_mem [ReqFifoDepth];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            full, push, pop;

  assign full        = count_q == CntW'(ReqFifoDepth);
  // A full buffer still accepts when the head leaves in the same cycle
  assign in_ready_o  = ~full | out_ready_i;
  assign out_valid_o = count_q != '0;
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(ReqFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(ReqFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_mem[wr_ptr_q] <= in_addr_i;
      type_mem[wr_ptr_q] <= in_type_i;
      priv_mem[wr_ptr_q] <= in_priv_i;
    end
  end

  assign out_addr_o = addr_mem[rd_ptr_q];
  assign out_type_o = type_mem[rd_ptr_q];
  assign out_priv_o = priv_mem[rd_ptr_q];

endmodule

/* rtl/pmp_checker.sv */
// PMP region checker
// Matches a request against all regions, applies PMP/Smepmp rules, registers the result

module pmp_checker #(
  parameter int unsigned PmpNumRegions  = 4,
  parameter int unsigned PmpGranularity = 0,
  parameter int unsigned DmBaseAddr     = 32'h1A11_0000,
  parameter int unsigned DmAddrMask     = 32'h0000_0FFF
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Register state
  input  pmp_pkg::pmp_cfg_t   cfg_i [PmpNumRegions],
  input  pmp_pkg::pmp_addr_t  addr_i [PmpNumRegions],
  input  pmp_pkg::mseccfg_t   mseccfg_i,
  input  logic                debug_mode_i,
  // Request from the buffer
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  pmp_pkg::phys_addr_t req_addr_i,
  input  pmp_pkg::pmp_req_e   req_type_i,
  input  pmp_pkg::priv_lvl_e  req_priv_i,
  // Response
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output logic                rsp_err_o,
  output pmp_pkg::phys_addr_t rsp_addr_o
);

  import pmp_pkg::*;

  // Lowest address register bit that holds NAPOT size information
  localparam int unsigned NapotLsb = (PmpGranularity == 0) ? 0 : PmpGranularity - 1;

  pmp_addr_t                  req_word;
  pmp_addr_t                  region_start [PmpNumRegions];
  logic [31:PmpGranularity]   region_mask  [PmpNumRegions];
  logic [PmpNumRegions-1:0]   region_match;
  logic [PmpNumRegions-1:0]   perm_ok;
  logic                       chk_err, dm_allow;
  logic                       rsp_valid_q, rsp_err_q;
  phys_addr_t                 rsp_addr_q;

  // Per-region permission, original PMP or Smepmp depending on MML
  function automatic logic perm_check(pmp_cfg_t cfg, pmp_req_e acc, priv_lvl_e priv,
                                      logic mml);
    logic rd, wr, ex, lk, m_mode, basic, res;
    rd     = cfg[PMP_CFG_R];
    wr     = cfg[PMP_CFG_W];
    ex     = cfg[PMP_CFG_X];
    lk     = cfg[PMP_CFG_L];
    m_mode = priv == PRIV_LVL_M;
    basic  = ((acc == PMP_ACC_EXEC) & ex) | ((acc == PMP_ACC_WRITE) & wr) |
             ((acc == PMP_ACC_READ) & rd);
    if (!mml) begin
      // M-mode only bound by locked regions
      res = m_mode ? (~lk | basic) : basic;
    end else if (!rd && wr) begin
      // Shared regions
      case ({lk, ex})
        2'b00:   res = (acc == PMP_ACC_READ) | ((acc == PMP_ACC_WRITE) & m_mode);
        2'b01:   res = (acc == PMP_ACC_READ) | (acc == PMP_ACC_WRITE);
        2'b10:   res = acc == PMP_ACC_EXEC;
        default: res = (acc == PMP_ACC_EXEC) | ((acc == PMP_ACC_READ) & m_mode);
      endcase
    end else if (rd && wr && ex && lk) begin
      // Shared read-only region
      res = acc == PMP_ACC_READ;
    end else begin
      // Locked regions belong to M-mode, unlocked ones to S/U
      res = basic & (m_mode ? lk : ~lk);
    end
    return res;
  endfunction

  // ------------------------------------------------------------------------
  // Address matching
  // ------------------------------------------------------------------------

  assign req_word = req_addr_i[PMP_ADDR_MSB:PMP_ADDR_LSB];

  for (genvar r = 0; r < PmpNumRegions; r++) begin : g_region
    pmp_mode_e mode;
    logic      match_eq, match_gt, match_lt;

    assign mode = pmp_mode_e'(cfg_i[r][PMP_CFG_MODE_LSB +: 2]);

    // TOR start is the previous address register, or zero for region 0
    if (r == 0) begin : g_first
      assign region_start[r] = (mode == PMP_MODE_TOR) ? '0 : addr_i[r];
    end else begin : g_rest
      assign region_start[r] = (mode == PMP_MODE_TOR) ? addr_i[r-1] : addr_i[r];
    end

    // NAPOT mask clears every bit below the lowest zero of the address
    for (genvar b = PmpGranularity; b < 32; b++) begin : g_mask
      if (b == 0) begin : g_bit0
        assign region_mask[r][b] = mode != PMP_MODE_NAPOT;
      end else begin : g_bitn
        assign region_mask[r][b] = (mode != PMP_MODE_NAPOT) | ~&addr_i[r][b-1:NapotLsb];
      end
    end

    // Comparators sized to the granule
    assign match_eq = (req_word[31:PmpGranularity] & region_mask[r]) ==
                      (region_start[r][31:PmpGranularity] & region_mask[r]);
    assign match_gt = req_word[31:PmpGranularity] > region_start[r][31:PmpGranularity];
    assign match_lt = req_word[31:PmpGranularity] < addr_i[r][31:PmpGranularity];

    assign region_match[r] = (mode == PMP_MODE_TOR) ? ((match_eq | match_gt) & match_lt) :
                             ((mode != PMP_MODE_OFF) & match_eq);

    assign perm_ok[r] = perm_check(cfg_i[r], req_type_i, req_priv_i, mseccfg_i[MSECCFG_MML]);
  end

  // ------------------------------------------------------------------------
  // Fault decision
  // ------------------------------------------------------------------------

  always_comb begin
    // Unmatched default
    chk_err = mseccfg_i[MSECCFG_MMWP] | (req_priv_i != PRIV_LVL_M) |
              (mseccfg_i[MSECCFG_MML] & (req_type_i == PMP_ACC_EXEC));
    // Walk downwards so the lowest matching region decides
    for (int r = int'(PmpNumRegions) - 1; r >= 0; r--) begin
      if (region_match[r]) begin
        chk_err = ~perm_ok[r];
      end
    end
  end

  // Debug Module range is always open in debug mode
  assign dm_allow = debug_mode_i & ((req_addr_i[31:0] & ~DmAddrMask) == DmBaseAddr);

  // Response register
  assign req_ready_o = ~rsp_valid_q | rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      rsp_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      rsp_err_q  <= chk_err & ~dm_allow;
      rsp_addr_q <= req_addr_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_err_o   = rsp_err_q;
  assign rsp_addr_o  = rsp_addr_q;

endmodule

/* rtl/pmp_unit_top.sv */
// PMP unit top level
// APB register block, request FIFO and region checker

module pmp_unit_top #(
  parameter int unsigned PmpNumRegions  = 4,
  parameter int unsigned PmpGranularity = 0,
  parameter int unsigned DmBaseAddr     = 32'h1A11_0000,
  parameter int unsigned DmAddrMask     = 32'h0000_0FFF,
  parameter int unsigned ReqFifoDepth   = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // APB
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [pmp_pkg::APB_AW-1:0] paddr_i,
  input  logic [31:0]                pwdata_i,
  output logic [31:0]                prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  input  logic                       debug_mode_i,
  // Request stream
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  pmp_pkg::phys_addr_t        req_addr_i,
  input  pmp_pkg::pmp_req_e          req_type_i,
  input  pmp_pkg::priv_lvl_e         req_priv_i,
  // Response stream
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output logic                       rsp_err_o,
  output pmp_pkg::phys_addr_t        rsp_addr_o
);

  import pmp_pkg::*;

  pmp_cfg_t   cfg [PmpNumRegions];
  pmp_addr_t  addr [PmpNumRegions];
  mseccfg_t   mseccfg;

  logic       fifo_valid, fifo_ready;
  phys_addr_t fifo_addr;
  pmp_req_e   fifo_type;
  priv_lvl_e  fifo_priv;

  pmp_apb_regs #(
    .PmpNumRegions (PmpNumRegions)
  ) i_pmp_apb_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg_o     (cfg),
    .addr_o    (addr),
    .mseccfg_o (mseccfg)
  );

  pmp_req_fifo #(
    .ReqFifoDepth (ReqFifoDepth)
  ) i_pmp_req_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .in_addr_i   (req_addr_i),
    .in_type_i   (req_type_i),
    .in_priv_i   (req_priv_i),
    .out_valid_o (fifo_valid),
    .out_ready_i (fifo_ready),
    .out_addr_o  (fifo_addr),
    .out_type_o  (fifo_type),
    .out_priv_o  (fifo_priv)
  );

  pmp_checker #(
    .PmpNumRegions  (PmpNumRegions),
    .PmpGranularity (PmpGranularity),
    .DmBaseAddr     (DmBaseAddr),
    .DmAddrMask     (DmAddrMask)
  ) i_pmp_checker (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cfg_i        (cfg),
    .addr_i       (addr),
    .mseccfg_i    (mseccfg),
    .debug_mode_i (debug_mode_i),
    .req_valid_i  (fifo_valid),
    .req_ready_o  (fifo_ready),
    .req_addr_i   (fifo_addr),
    .req_type_i   (fifo_type),
    .req_priv_i   (fifo_priv),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_err_o    (rsp_err_o),
    .rsp_addr_o   (rsp_addr_o)
  );

endmodule

/* testbench/tb_pmp_unit.sv */
// PMP unit testbench
// Directed tests for APB programming, region matching, locks, Smepmp, debug bypass and streaming

module tb_pmp_unit;

  import pmp_pkg::*;

  localparam int NumRegions = 4;
  localparam int FifoDepth  = 4;
  localparam int ClkPeriod  = 20;
  // Request count over all tests and a generous cycle budget per request
  localparam int NumReqs    = 160;
  localparam int ReqBudget  = 40;
  localparam logic [31:0] DmBase = 32'h1A11_0000;
  localparam logic [31:0] DmMask = 32'h0000_0FFF;

  logic clk, rst_n;
  logic psel, penable, pwrite, pready, pslverr, debug_mode;
  logic [APB_AW-1:0] paddr;
  logic [31:0] pwdata, prdata;
  logic req_valid, req_ready, rsp_valid, rsp_ready, rsp_err;
  phys_addr_t req_addr, rsp_addr;
  pmp_req_e req_type;
  priv_lvl_e req_priv;

  // Expected register state as the lock rules leave it
  pmp_cfg_t  cfg_sh [NumRegions];
  pmp_addr_t addr_sh [NumRegions];
  mseccfg_t  msec_sh;
  int errors, checks;
  logic [31:0] rng;
  phys_addr_t exp_addr_q [$];
  logic exp_err_q [$];

  pmp_unit_top i_pmp_unit_top (
    .clk_i (clk), .rst_n_i (rst_n),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .debug_mode_i (debug_mode),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_addr_i (req_addr),
    .req_type_i (req_type), .req_priv_i (req_priv),
    .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready), .rsp_err_o (rsp_err),
    .rsp_addr_o (rsp_addr)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(NumReqs * ReqBudget * ClkPeriod);
    $display("Watchdog timeout, the DUT stopped responding");
    $display("=== FAIL ===");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Helpers and reference model
  // --------------------------------------------------------------------------

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic region_hit(int r, logic [31:0] w);
    logic [31:0] lo, size;
    int t;
    lo = '0;
    t = 0;
    case (cfg_sh[r][4:3])
      2'b01: begin
        if (r > 0) lo = addr_sh[r-1];
        return (w >= lo) && (w < addr_sh[r]);
      end
      2'b10: return w == addr_sh[r];
      2'b11: begin
        // Trailing ones give the region size in words
        while (t < 32 && addr_sh[r][t]) t++;
        if (t >= 31) return 1'b1;
        size = 32'd1 << (t + 1);
        return (w & ~(size - 1)) == (addr_sh[r] & ~(size - 1));
      end
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic allowed(pmp_cfg_t c, pmp_req_e acc, priv_lvl_e priv, logic mml);
    logic rd, wr, ex, lk, m, want;
    rd = c[0];
    wr = c[1];
    ex = c[2];
    lk = c[7];
    m  = priv == PRIV_LVL_M;
    want = (acc == PMP_ACC_EXEC) ? ex : (acc == PMP_ACC_WRITE) ? wr : rd;
    if (!mml) return lk ? want : (m || want);
    // Smepmp table keyed by L R W X
    case ({lk, rd, wr, ex})
      4'b0010: return acc == PMP_ACC_READ || (acc == PMP_ACC_WRITE && m);
      4'b0011: return acc != PMP_ACC_EXEC;
      4'b1010: return acc == PMP_ACC_EXEC;
      4'b1011: return acc == PMP_ACC_EXEC || (acc == PMP_ACC_READ && m);
      4'b1111: return acc == PMP_ACC_READ;
      default: return want && (lk == m);
    endcase
  endfunction

  function automatic logic expected_err(phys_addr_t a, pmp_req_e acc, priv_lvl_e priv);
    if (debug_mode && ((a[31:0] & ~DmMask) == DmBase)) return 1'b0;
    for (int r = 0; r < NumRegions; r++) begin
      if (region_hit(r, a[33:2])) return !allowed(cfg_sh[r], acc, priv, msec_sh[0]);
    end
    return msec_sh[1] || priv != PRIV_LVL_M || (msec_sh[0] && acc == PMP_ACC_EXEC);
  endfunction

  function automatic logic is_mapped(logic [APB_AW-1:0] a);
    return (a[1:0] == 2'b00 && a[11:7] == 5'd0 && a[5:2] < NumRegions) || a == REG_MSECCFG;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < NumRegions; r++) begin
      cfg_sh[r]  = '0;
      addr_sh[r] = '0;
    end
    msec_sh = '0;
  endtask

  // --------------------------------------------------------------------------
  // Bus and stream drivers
  // --------------------------------------------------------------------------

  task automatic apb_write(logic [APB_AW-1:0] a, logic [31:0] d);
    int i;
    logic any_lock, tor_next;
    i = a[5:2];
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b1;
    paddr <= a;
    pwdata <= d;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    check_value("pready on write", pready, 1'b1);
    check_value("pslverr on write", pslverr, !is_mapped(a));
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
    if (!is_mapped(a)) return;
    any_lock = 1'b0;
    for (int r = 0; r < NumRegions; r++) any_lock |= cfg_sh[r][7];
    if (a == REG_MSECCFG) begin
      msec_sh[0] = msec_sh[0] | d[0];
      msec_sh[1] = msec_sh[1] | d[1];
      if (!any_lock) msec_sh[2] = d[2];
    end else if (a[6]) begin
      tor_next = (i + 1 < NumRegions) && cfg_sh[(i+1)%NumRegions][7] &&
                 cfg_sh[(i+1)%NumRegions][4:3] == 2'b01;
      if (msec_sh[2] || !(cfg_sh[i][7] || tor_next)) addr_sh[i] = d;
    end else if (msec_sh[2] || !cfg_sh[i][7]) begin
      cfg_sh[i] = d[7:0];
    end
  endtask

  task automatic apb_read(logic [APB_AW-1:0] a, output logic [31:0] d);
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= a;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    d = prdata;
    check_value("pready on read", pready, 1'b1);
    check_value("pslverr on read", pslverr, !is_mapped(a));
    @(posedge clk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_check(logic [APB_AW-1:0] a, logic [31:0] exp);
    logic [31:0] d;
    apb_read(a, d);
    check_value("register read", d, exp);
  endtask

  task automatic send_req(phys_addr_t a, pmp_req_e acc, priv_lvl_e priv);
    @(posedge clk);
    req_valid <= 1'b1;
    req_addr <= a;
    req_type <= acc;
    req_priv <= priv;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  task automatic expect_rsp(phys_addr_t a, logic err);
    @(negedge clk);
    while (!(rsp_valid && rsp_ready)) @(negedge clk);
    check_value("response address", rsp_addr, a);
    check_value("response error", rsp_err, err);
    @(posedge clk);
  endtask

  task automatic check_access(phys_addr_t a, pmp_req_e acc, priv_lvl_e priv);
    send_req(a, acc, priv);
    // Model is evaluated once the register state for this request is settled
    expect_rsp(a, expected_err(a, acc, priv));
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic reset_and_regs();
    for (int r = 0; r < NumRegions; r++) begin
      read_check(REG_CFG_BASE + 12'(4 * r), 32'h0);
      read_check(REG_ADDR_BASE + 12'(4 * r), 32'h0);
    end
    read_check(REG_MSECCFG, 32'h0);
    apb_write(REG_ADDR_BASE + 12'h4, 32'h1234_5678);
    read_check(REG_ADDR_BASE + 12'h4, 32'h1234_5678);
    apb_write(REG_CFG_BASE + 12'h8, 32'h0000_0005);
    read_check(REG_CFG_BASE + 12'h8, 32'h0000_0005);
    // Holes in the map and a region beyond the implemented count
    apb_write(12'h0C4, 32'hFFFF_FFFF);
    read_check(REG_CFG_BASE + 12'h10, 32'h0);
    check_access(34'h0_4000_0000, PMP_ACC_READ, PRIV_LVL_M);
    check_access(34'h0_4000_0000, PMP_ACC_READ, PRIV_LVL_U);
  endtask

  task automatic region_matching();
    logic [31:0] base [4] = '{32'h0, 32'h2000_0000, 32'h3000_0000, 32'h3000_0000};
    logic [31:0] size [4] = '{32'h1000_0000, 32'h4, 32'h1000, 32'h1_0000};
    pmp_req_e accs [3] = '{PMP_ACC_READ, PMP_ACC_WRITE, PMP_ACC_EXEC};
    priv_lvl_e privs [3] = '{PRIV_LVL_U, PRIV_LVL_S, PRIV_LVL_M};
    logic [31:0] a;
    int r;
    apply_reset();
    // TOR read-only, NA4 read/write, small NAPOT exec inside a larger NAPOT RWX
    apb_write(REG_ADDR_BASE + 12'h0, 32'h0400_0000);
    apb_write(REG_ADDR_BASE + 12'h4, 32'h0800_0000);
    apb_write(REG_ADDR_BASE + 12'h8, 32'h0C00_01FF);
    apb_write(REG_ADDR_BASE + 12'hC, 32'h0C00_1FFF);
    apb_write(REG_CFG_BASE + 12'h0, 32'h09);
    apb_write(REG_CFG_BASE + 12'h4, 32'h13);
    apb_write(REG_CFG_BASE + 12'h8, 32'h1C);
    apb_write(REG_CFG_BASE + 12'hC, 32'h1F);
    for (int k = 0; k < 40; k++) begin
      r = next_rand() % 4;
      if (next_rand() % 4 != 0) a = base[r] + ((next_rand() % size[r]) & ~32'h3);
      else a = next_rand() & ~32'h3;
      check_access({2'b00, a}, accs[next_rand() % 3], privs[next_rand() % 3]);
    end
    // Region 2 decides in its own 4 KiB and region 3 beyond it
    check_access(34'h0_3000_0010, PMP_ACC_READ, PRIV_LVL_U);
    check_access(34'h0_3000_8000, PMP_ACC_READ, PRIV_LVL_U);
  endtask

  task automatic lock_rules();
    apply_reset();
    apb_write(REG_ADDR_BASE + 12'h0, 32'h0400_0000);
    apb_write(REG_ADDR_BASE + 12'h4, 32'h0500_0000);
    apb_write(REG_CFG_BASE + 12'h4, 32'h89);
    apb_write(REG_CFG_BASE + 12'h4, 32'h1F);
    apb_write(REG_ADDR_BASE + 12'h4, 32'h0600_0000);
    apb_write(REG_ADDR_BASE + 12'h0, 32'h0100_0000);
    apb_write(REG_ADDR_BASE + 12'h8, 32'h0000_0007);
    read_check(REG_CFG_BASE + 12'h4, 32'h89);
    read_check(REG_ADDR_BASE + 12'h4, 32'h0500_0000);
    read_check(REG_ADDR_BASE + 12'h0, 32'h0400_0000);
    read_check(REG_ADDR_BASE + 12'h8, 32'h0000_0007);
    // Locked region now binds M-mode
    check_access(34'h0_1000_0000, PMP_ACC_READ, PRIV_LVL_M);
    check_access(34'h0_1000_0000, PMP_ACC_WRITE, PRIV_LVL_M);
    check_access(34'h0_1000_0000, PMP_ACC_EXEC, PRIV_LVL_M);
    apb_write(REG_MSECCFG, 32'h4);
    read_check(REG_MSECCFG, 32'h0);
    // RLB before the lock keeps every register writable
    apply_reset();
    apb_write(REG_MSECCFG, 32'h4);
    apb_write(REG_CFG_BASE + 12'h4, 32'h89);
    apb_write(REG_CFG_BASE + 12'h4, 32'h8B);
    apb_write(REG_ADDR_BASE + 12'h4, 32'h0600_0000);
    apb_write(REG_ADDR_BASE + 12'h0, 32'h0100_0000);
    read_check(REG_CFG_BASE + 12'h4, 32'h8B);
    read_check(REG_ADDR_BASE + 12'h4, 32'h0600_0000);
    read_check(REG_ADDR_BASE + 12'h0, 32'h0100_0000);
    check_access(34'h0_1000_0000, PMP_ACC_WRITE, PRIV_LVL_M);
  endtask

  task automatic smepmp_modes();
    logic [3:0] enc [8] = '{4'b0010, 4'b0011, 4'b1010, 4'b1011,
                            4'b1111, 4'b0111, 4'b1100, 4'b0000};
    pmp_req_e accs [3] = '{PMP_ACC_READ, PMP_ACC_WRITE, PMP_ACC_EXEC};
    priv_lvl_e privs [3] = '{PRIV_LVL_U, PRIV_LVL_S, PRIV_LVL_M};
    apply_reset();
    apb_write(REG_MSECCFG, 32'h5);
    read_check(REG_MSECCFG, 32'h5);
    check_access(34'h0_5000_0000, PMP_ACC_EXEC, PRIV_LVL_M);
    check_access(34'h0_5000_0000, PMP_ACC_READ, PRIV_LVL_M);
    apb_write(REG_ADDR_BASE + 12'h0, 32'h1000_01FF);
    for (int e = 0; e < 8; e++) begin
      // L, NAPOT, then X W R
      apb_write(REG_CFG_BASE, {24'h0, enc[e][3], 4'b0011, enc[e][0], enc[e][1], enc[e][2]});
      for (int p = 0; p < 3; p++) begin
        for (int t = 0; t < 3; t++) check_access(34'h0_4000_0100, accs[t], privs[p]);
      end
    end
    apb_write(REG_MSECCFG, 32'h0);
    read_check(REG_MSECCFG, 32'h1);
    apb_write(REG_MSECCFG, 32'h2);
    apb_write(REG_MSECCFG, 32'h0);
    read_check(REG_MSECCFG, 32'h3);
    check_access(34'h0_5000_0000, PMP_ACC_READ, PRIV_LVL_M);
  endtask

  task automatic debug_bypass();
    apply_reset();
    check_access(34'h0_1A11_0004, PMP_ACC_READ, PRIV_LVL_U);
    @(posedge clk);
    debug_mode <= 1'b1;
    check_access(34'h0_1A11_0004, PMP_ACC_READ, PRIV_LVL_U);
    check_access(34'h0_1A12_0000, PMP_ACC_READ, PRIV_LVL_U);
    @(posedge clk);
    debug_mode <= 1'b0;
  endtask

  task automatic stream_flow();
    int accepted;
    int lat;
    phys_addr_t a;
    priv_lvl_e p;
    accepted = 0;
    @(posedge clk);
    rsp_ready <= 1'b0;
    // Fill until the buffer and the held response stop the stream
    for (int k = 0; k < 12; k++) begin
      a = 34'h0_0000_1000 + 34'(4 * k);
      p = k[0] ? PRIV_LVL_U : PRIV_LVL_M;
      if (k == 0) @(posedge clk);
      req_valid <= 1'b1;
      req_addr <= a;
      req_type <= PMP_ACC_READ;
      req_priv <= p;
      @(negedge clk);
      if (!req_ready) break;
      @(posedge clk);
      exp_addr_q.push_back(a);
      exp_err_q.push_back(expected_err(a, PMP_ACC_READ, p));
      accepted++;
    end
    @(posedge clk);
    req_valid <= 1'b0;
    check_value("requests accepted under back-pressure", accepted, FifoDepth + 1);
    rsp_ready <= 1'b1;
    while (exp_addr_q.size() > 0) begin
      @(negedge clk);
      if (rsp_valid && rsp_ready) begin
        check_value("queued response address", rsp_addr, exp_addr_q.pop_front());
        check_value("queued response error", rsp_err, exp_err_q.pop_front());
      end
    end
    // Latency with a free path
    send_req(34'h0_0000_2000, PMP_ACC_READ, PRIV_LVL_M);
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
    end while (!rsp_valid);
    check_value("response latency", lat, 2);
    check_value("latency response address", rsp_addr, 34'h0_0000_2000);
    @(posedge clk);
  endtask

  initial begin
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    debug_mode = 1'b0;
    req_valid = 1'b0;
    req_addr = '0;
    req_type = PMP_ACC_READ;
    req_priv = PRIV_LVL_M;
    rsp_ready = 1'b1;
    rng = 32'h5db2_114b;
    errors = 0;
    checks = 0;
    for (int r = 0; r < NumRegions; r++) begin
      cfg_sh[r]  = '0;
      addr_sh[r] = '0;
    end
    msec_sh = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    reset_and_regs();
    region_matching();
    lock_rules();
    smepmp_modes();
    debug_bypass();
    stream_flow();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* compile.f */
rtl/pmp_pkg.sv
rtl/pmp_apb_regs.sv
rtl/pmp_req_fifo.sv
rtl/pmp_checker.sv
rtl/pmp_unit_top.sv
testbench/tb_pmp_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the PMP unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_pmp_unit -o sim_pmp_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_pmp_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
